// File: verilog/kernel_loader_pkg.sv
package kernel_loader_pkg;

    // ****************************************
    // loader geometry
    // ****************************************

    // kernels served in turn
    localparam int num_kernels = 5;

    // AXI read side
    localparam int addr_width = 32;
    localparam int data_width = 64;

    // one beat is one full data word
    localparam int beat_bytes = data_width / 8;

    // fixed INCR burst length
    localparam int burst_beats = 8;

    // ****************************************
    // output FIFO side
    // ****************************************

    localparam int count_width = 8;

    // room for one more burst above this level
    localparam int almost_full_level = 200;

    // kernel index
    localparam int sel_width = $clog2(num_kernels);

    // ****************************************
    // read engine states
    // ****************************************

    typedef enum logic [1:0] {
        reader_idle,
        reader_addr,
        reader_data,
        reader_settle
    } reader_state_e;

endpackage

// File: verilog/kernel_channel.sv
`timescale 1ns/100ps

module kernel_channel
    import kernel_loader_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic [addr_width-1:0]  start_addr,
    input  logic [addr_width-1:0]  end_addr,
    input  logic                   wrap_en,
    input  logic [count_width-1:0] fifo_count,
    input  logic [sel_width-1:0]   sel_index,
    input  logic [sel_width-1:0]   channel_id,
    input  logic                   beat_valid,
    input  logic [data_width-1:0]  beat_data,
    input  logic                   burst_done,
    output logic [addr_width-1:0]  cur_addr,
    output logic                   almost_full,
    output logic                   done,
    output logic [data_width-1:0]  fifo_wr_data,
    output logic                   fifo_wr_en
);

    logic                  selected;
    logic [addr_width-1:0] stepped_addr;
    logic [addr_width-1:0] next_addr;

    assign selected = (sel_index == channel_id);

    // ****************************************
    // address tracking
    // ****************************************

    // address once this cycle's beat is counted
    always_comb begin
        stepped_addr = cur_addr;
        if (selected && beat_valid) begin
            stepped_addr = cur_addr + addr_width'(beat_bytes);
        end
    end

    // the last beat and burst_done land on the same cycle,
    // so the wrap test looks at the stepped address
    always_comb begin
        next_addr = stepped_addr;
        if (start) begin
            next_addr = start_addr;
        end else if (selected && burst_done && wrap_en && (stepped_addr >= end_addr)) begin
            next_addr = start_addr;
        end
    end

    // done follows the address it will hold next cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cur_addr <= '0;
            done     <= 1'b0;
        end else begin
            cur_addr <= next_addr;
            done     <= (next_addr >= end_addr);
        end
    end

    // ****************************************
    // FIFO side
    // ****************************************

    // fill level sampled every cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            almost_full <= 1'b0;
        end else begin
            almost_full <= (fifo_count > count_width'(almost_full_level));
        end
    end

    // beats past the end of the range are dropped
    assign fifo_wr_en   = selected && beat_valid && !done;
    assign fifo_wr_data = beat_data;

endmodule

// File: verilog/kernel_scheduler.sv
`timescale 1ns/100ps

module kernel_scheduler
    import kernel_loader_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  start,
    input  logic [num_kernels-1:0]                skip_en,
    input  logic [num_kernels-1:0][addr_width-1:0] chan_addr,
    input  logic [num_kernels-1:0]                almost_full,
    input  logic [num_kernels-1:0]                done,
    input  logic                                  reader_idle,
    input  logic                                  burst_done,
    output logic [sel_width-1:0]                  sel_index,
    output logic                                  issue,
    output logic [addr_width-1:0]                 issue_addr
);

    logic                 running;
    logic                 burst_pending;
    logic                 pass_over;
    logic                 can_decide;
    logic [sel_width-1:0] next_index;

    // kernel not eligible for a burst this round
    assign pass_over = skip_en[sel_index] | almost_full[sel_index] | done[sel_index];

    // round robin wraps from the last kernel back to 0
    assign next_index = (sel_index == sel_width'(num_kernels - 1)) ?
                        '0 : sel_index + 1'b1;

    // one decision per cycle while nothing is in flight
    assign can_decide = running && reader_idle && !burst_pending;

    // ****************************************
    // selection and burst issue
    // ****************************************

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            running       <= 1'b0;
            sel_index     <= '0;
            issue         <= 1'b0;
            burst_pending <= 1'b0;
        end else if (start) begin
            running       <= 1'b1;
            sel_index     <= '0;
            issue         <= 1'b0;
            burst_pending <= 1'b0;
        end else begin
            issue <= 1'b0;
            if (burst_done) begin
                // burst finished so hand over to the next kernel
                sel_index     <= next_index;
                burst_pending <= 1'b0;
            end else if (can_decide) begin
                if (pass_over) begin
                    sel_index <= next_index;
                end else begin
                    issue         <= 1'b1;
                    burst_pending <= 1'b1;
                end
            end
        end
    end

    // start address of the burst handed to the reader
    always_ff @(posedge clk) begin
        if (can_decide && !pass_over) begin
            issue_addr <= chan_addr[sel_index];
        end
    end

endmodule

// File: verilog/axi_burst_reader.sv
`timescale 1ns/100ps

module axi_burst_reader
    import kernel_loader_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  logic                  issue,
    input  logic [addr_width-1:0] issue_addr,
    // read address channel
    output logic [addr_width-1:0] m_axi_araddr,
    output logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    // read data channel
    input  logic [data_width-1:0] m_axi_rdata,
    input  logic                  m_axi_rlast,
    input  logic                  m_axi_rvalid,
    output logic                  m_axi_rready,
    // towards scheduler and channels
    output logic                  reader_idle,
    output logic                  beat_valid,
    output logic [data_width-1:0] beat_data,
    output logic                  burst_done
);

    reader_state_e state;
    logic          ar_handshake;
    logic          r_handshake;

    assign ar_handshake = m_axi_arvalid & m_axi_arready;
    assign r_handshake  = m_axi_rvalid & m_axi_rready;

    // the idle port and the idle state share a name
    assign reader_idle = (state == kernel_loader_pkg::reader_idle);

    // ****************************************
    // burst state machine
    // ****************************************

    // start restarts the engine like reset does
    always_ff @(posedge clk) begin
        if (!reset_n || start) begin
            state         <= kernel_loader_pkg::reader_idle;
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            burst_done    <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            case (state)
                kernel_loader_pkg::reader_idle: begin
                    if (issue) begin
                        state         <= reader_addr;
                        m_axi_arvalid <= 1'b1;
                    end
                end
                reader_addr: begin
                    // address held until the slave takes it
                    if (ar_handshake) begin
                        state         <= reader_data;
                        m_axi_arvalid <= 1'b0;
                        m_axi_rready  <= 1'b1;
                    end
                end
                reader_data: begin
                    if (r_handshake && m_axi_rlast) begin
                        state        <= reader_settle;
                        m_axi_rready <= 1'b0;
                        burst_done   <= 1'b1;
                    end
                end
                reader_settle: begin
                    // last beat reaches the channels this cycle
                    state <= kernel_loader_pkg::reader_idle;
                end
                default: begin
                    state <= kernel_loader_pkg::reader_idle;
                end
            endcase
        end
    end

    // burst address latched with the issue strobe
    always_ff @(posedge clk) begin
        if (reader_idle && issue) begin
            m_axi_araddr <= issue_addr;
        end
    end

    // ****************************************
    // beat output
    // ****************************************

    always_ff @(posedge clk) begin
        if (!reset_n || start) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= r_handshake;
        end
    end

    always_ff @(posedge clk) begin
        if (r_handshake) begin
            beat_data <= m_axi_rdata;
        end
    end

endmodule

// File: verilog/kernel_loader.sv
`timescale 1ns/100ps

module kernel_loader
    import kernel_loader_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic [num_kernels-1:0] skip_en,
    // kernel 0
    input  logic [addr_width-1:0]  kernel_0_start_addr,
    input  logic [addr_width-1:0]  kernel_0_end_addr,
    input  logic                   kernel_0_wrap_en,
    input  logic [count_width-1:0] kernel_0_fifo_count,
    output logic [data_width-1:0]  kernel_0_fifo_wr_data,
    output logic                   kernel_0_fifo_wr_en,
    // kernel 1
    input  logic [addr_width-1:0]  kernel_1_start_addr,
    input  logic [addr_width-1:0]  kernel_1_end_addr,
    input  logic                   kernel_1_wrap_en,
    input  logic [count_width-1:0] kernel_1_fifo_count,
    output logic [data_width-1:0]  kernel_1_fifo_wr_data,
    output logic                   kernel_1_fifo_wr_en,
    // kernel 2
    input  logic [addr_width-1:0]  kernel_2_start_addr,
    input  logic [addr_width-1:0]  kernel_2_end_addr,
    input  logic                   kernel_2_wrap_en,
    input  logic [count_width-1:0] kernel_2_fifo_count,
    output logic [data_width-1:0]  kernel_2_fifo_wr_data,
    output logic                   kernel_2_fifo_wr_en,
    // kernel 3
    input  logic [addr_width-1:0]  kernel_3_start_addr,
    input  logic [addr_width-1:0]  kernel_3_end_addr,
    input  logic                   kernel_3_wrap_en,
    input  logic [count_width-1:0] kernel_3_fifo_count,
    output logic [data_width-1:0]  kernel_3_fifo_wr_data,
    output logic                   kernel_3_fifo_wr_en,
    // kernel 4
    input  logic [addr_width-1:0]  kernel_4_start_addr,
    input  logic [addr_width-1:0]  kernel_4_end_addr,
    input  logic                   kernel_4_wrap_en,
    input  logic [count_width-1:0] kernel_4_fifo_count,
    output logic [data_width-1:0]  kernel_4_fifo_wr_data,
    output logic                   kernel_4_fifo_wr_en,
    // AXI read address channel
    output logic [addr_width-1:0]  m_axi_araddr,
    output logic                   m_axi_arvalid,
    input  logic                   m_axi_arready,
    // AXI read data channel
    input  logic [data_width-1:0]  m_axi_rdata,
    input  logic                   m_axi_rlast,
    input  logic                   m_axi_rvalid,
    output logic                   m_axi_rready
);

    // per kernel buses, index k is kernel k
    logic [num_kernels-1:0][addr_width-1:0]  start_addr_vec;
    logic [num_kernels-1:0][addr_width-1:0]  end_addr_vec;
    logic [num_kernels-1:0]                  wrap_en_vec;
    logic [num_kernels-1:0][count_width-1:0] fifo_count_vec;
    logic [num_kernels-1:0][data_width-1:0]  wr_data_vec;
    logic [num_kernels-1:0]                  wr_en_vec;
    logic [num_kernels-1:0][addr_width-1:0]  chan_addr;
    logic [num_kernels-1:0]                  almost_full;
    logic [num_kernels-1:0]                  done;

    // scheduler and reader handshakes
    logic [sel_width-1:0]  sel_index;
    logic                  issue;
    logic [addr_width-1:0] issue_addr;
    logic                  reader_idle;
    logic                  beat_valid;
    logic [data_width-1:0] beat_data;
    logic                  burst_done;

    assign start_addr_vec = {kernel_4_start_addr, kernel_3_start_addr, kernel_2_start_addr,
                             kernel_1_start_addr, kernel_0_start_addr};
    assign end_addr_vec   = {kernel_4_end_addr, kernel_3_end_addr, kernel_2_end_addr,
                             kernel_1_end_addr, kernel_0_end_addr};
    assign wrap_en_vec    = {kernel_4_wrap_en, kernel_3_wrap_en, kernel_2_wrap_en,
                             kernel_1_wrap_en, kernel_0_wrap_en};
    assign fifo_count_vec = {kernel_4_fifo_count, kernel_3_fifo_count, kernel_2_fifo_count,
                             kernel_1_fifo_count, kernel_0_fifo_count};

    assign {kernel_4_fifo_wr_data, kernel_3_fifo_wr_data, kernel_2_fifo_wr_data,
            kernel_1_fifo_wr_data, kernel_0_fifo_wr_data} = wr_data_vec;
    assign {kernel_4_fifo_wr_en, kernel_3_fifo_wr_en, kernel_2_fifo_wr_en,
            kernel_1_fifo_wr_en, kernel_0_fifo_wr_en} = wr_en_vec;

    kernel_scheduler u_scheduler (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .skip_en     (skip_en),
        .chan_addr   (chan_addr),
        .almost_full (almost_full),
        .done        (done),
        .reader_idle (reader_idle),
        .burst_done  (burst_done),
        .sel_index   (sel_index),
        .issue       (issue),
        .issue_addr  (issue_addr)
    );

    axi_burst_reader u_reader (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .issue         (issue),
        .issue_addr    (issue_addr),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready),
        .reader_idle   (reader_idle),
        .beat_valid    (beat_valid),
        .beat_data     (beat_data),
        .burst_done    (burst_done)
    );

    // one channel per kernel
    for (genvar k = 0; k < num_kernels; k++) begin : g_channel
        kernel_channel u_channel (
            .clk          (clk),
            .reset_n      (reset_n),
            .start        (start),
            .start_addr   (start_addr_vec[k]),
            .end_addr     (end_addr_vec[k]),
            .wrap_en      (wrap_en_vec[k]),
            .fifo_count   (fifo_count_vec[k]),
            .sel_index    (sel_index),
            .channel_id   (sel_width'(k)),
            .beat_valid   (beat_valid),
            .beat_data    (beat_data),
            .burst_done   (burst_done),
            .cur_addr     (chan_addr[k]),
            .almost_full  (almost_full[k]),
            .done         (done[k]),
            .fifo_wr_data (wr_data_vec[k]),
            .fifo_wr_en   (wr_en_vec[k])
        );
    end

endmodule

// File: tests/kernel_loader_assertions.sv
`timescale 1ns/100ps

module kernel_loader_assertions
    import kernel_loader_pkg::*;
(
    input logic                   clk,
    input logic                   reset_n,
    input logic                   start,
    input logic [num_kernels-1:0] skip_en,
    input logic [addr_width-1:0]  kernel_0_start_addr, kernel_0_end_addr,
    input logic [addr_width-1:0]  kernel_1_start_addr, kernel_1_end_addr,
    input logic [addr_width-1:0]  kernel_2_start_addr, kernel_2_end_addr,
    input logic [addr_width-1:0]  kernel_3_start_addr, kernel_3_end_addr,
    input logic [addr_width-1:0]  kernel_4_start_addr, kernel_4_end_addr,
    input logic                   kernel_0_wrap_en, kernel_1_wrap_en, kernel_2_wrap_en,
    input logic                   kernel_3_wrap_en, kernel_4_wrap_en,
    input logic [count_width-1:0] kernel_0_fifo_count, kernel_1_fifo_count,
    input logic [count_width-1:0] kernel_2_fifo_count, kernel_3_fifo_count,
    input logic [count_width-1:0] kernel_4_fifo_count,
    input logic [data_width-1:0]  kernel_0_fifo_wr_data, kernel_1_fifo_wr_data,
    input logic [data_width-1:0]  kernel_2_fifo_wr_data, kernel_3_fifo_wr_data,
    input logic [data_width-1:0]  kernel_4_fifo_wr_data,
    input logic                   kernel_0_fifo_wr_en, kernel_1_fifo_wr_en,
    input logic                   kernel_2_fifo_wr_en, kernel_3_fifo_wr_en,
    input logic                   kernel_4_fifo_wr_en,
    input logic [addr_width-1:0]  m_axi_araddr,
    input logic                   m_axi_arvalid,
    input logic                   m_axi_arready,
    input logic                   m_axi_rlast,
    input logic                   m_axi_rvalid,
    input logic                   m_axi_rready
);

    int fail_count = 0;

    logic [num_kernels-1:0][addr_width-1:0]  s_a;
    logic [num_kernels-1:0][addr_width-1:0]  e_a;
    logic [num_kernels-1:0][count_width-1:0] cnt;
    logic [num_kernels-1:0][data_width-1:0]  wr_data;
    logic [num_kernels-1:0]                  wrap;
    logic [num_kernels-1:0]                  wr_en;
    logic [addr_width-1:0] burst_addr [num_kernels];
    logic [addr_width-1:0] exp_w [num_kernels];
    logic [2:0]            last_k;
    logic [2:0]            exp_k;
    logic                  found;
    logic                  burst_open;
    logic                  ar_hs;
    logic                  r_hs;
    int                    cand;

    assign s_a = {kernel_4_start_addr, kernel_3_start_addr, kernel_2_start_addr,
                  kernel_1_start_addr, kernel_0_start_addr};
    assign e_a = {kernel_4_end_addr, kernel_3_end_addr, kernel_2_end_addr,
                  kernel_1_end_addr, kernel_0_end_addr};
    assign cnt = {kernel_4_fifo_count, kernel_3_fifo_count, kernel_2_fifo_count,
                  kernel_1_fifo_count, kernel_0_fifo_count};
    assign wrap = {kernel_4_wrap_en, kernel_3_wrap_en, kernel_2_wrap_en,
                   kernel_1_wrap_en, kernel_0_wrap_en};
    assign wr_en = {kernel_4_fifo_wr_en, kernel_3_fifo_wr_en, kernel_2_fifo_wr_en,
                    kernel_1_fifo_wr_en, kernel_0_fifo_wr_en};
    assign wr_data = {kernel_4_fifo_wr_data, kernel_3_fifo_wr_data, kernel_2_fifo_wr_data,
                      kernel_1_fifo_wr_data, kernel_0_fifo_wr_data};
    assign ar_hs = m_axi_arvalid && m_axi_arready;
    assign r_hs  = m_axi_rvalid && m_axi_rready;

    // ****************************************
    // reference round robin
    // ****************************************

    // next eligible kernel after the last one served
    always_comb begin
        exp_k = last_k;
        found = 1'b0;
        for (int i = 1; i <= num_kernels; i++) begin
            cand = (int'(last_k) + i) % num_kernels;
            if (!found && !skip_en[cand] && cnt[cand] <= count_width'(almost_full_level)
                && (wrap[cand] || burst_addr[cand] < e_a[cand])) begin
                exp_k = 3'(cand);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || start) begin
            last_k     <= 3'(num_kernels - 1);
            burst_open <= 1'b0;
            for (int k = 0; k < num_kernels; k++) begin
                burst_addr[k] <= s_a[k];
                exp_w[k]      <= s_a[k];
            end
        end else begin
            if (ar_hs) begin
                last_k     <= exp_k;
                burst_open <= 1'b1;
                if (wrap[exp_k]
                    && burst_addr[exp_k] + burst_beats * beat_bytes >= e_a[exp_k]) begin
                    burst_addr[exp_k] <= s_a[exp_k];
                end else begin
                    burst_addr[exp_k] <= burst_addr[exp_k] + burst_beats * beat_bytes;
                end
            end
            if (r_hs && m_axi_rlast) begin
                burst_open <= 1'b0;
            end
            for (int k = 0; k < num_kernels; k++) begin
                if (wr_en[k]) begin
                    exp_w[k] <= (wrap[k] && exp_w[k] + beat_bytes >= e_a[k]) ?
                                s_a[k] : exp_w[k] + beat_bytes;
                end
            end
        end
    end

    // ****************************************
    // checks
    // ****************************************

    a_quiet: assert property (@(posedge clk) (!reset_n || start) |=>
        (!m_axi_arvalid && !m_axi_rready && wr_en == '0))
        else begin $error("outputs active after reset or start"); fail_count++; end

    a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n || start)
        (m_axi_arvalid && !m_axi_arready) |=> (m_axi_arvalid && $stable(m_axi_araddr)))
        else begin $error("arvalid dropped or araddr changed"); fail_count++; end

    a_one_burst: assert property (@(posedge clk) disable iff (!reset_n)
        m_axi_arvalid |-> !burst_open)
        else begin $error("address issued during open burst"); fail_count++; end

    a_order: assert property (@(posedge clk) disable iff (!reset_n)
        ar_hs |-> (found && m_axi_araddr == burst_addr[exp_k]))
        else begin $error("burst address out of round robin order"); fail_count++; end

    a_wr_timing: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_en != '0) |-> ($past(r_hs) && $onehot0(wr_en)))
        else begin $error("write not one cycle after a beat"); fail_count++; end

    for (genvar k = 0; k < num_kernels; k++) begin : g_data
        a_data: assert property (@(posedge clk) disable iff (!reset_n)
            wr_en[k] |-> (wr_data[k] == {~exp_w[k], exp_w[k]} && exp_w[k] < e_a[k]))
            else begin $error("kernel write data wrong"); fail_count++; end
    end

endmodule

bind kernel_loader kernel_loader_assertions u_assert (.*);

// File: tests/kernel_loader_tb.sv
`timescale 1ns/100ps

module kernel_loader_tb;
    import kernel_loader_pkg::*;

    logic clk = 1'b0;
    logic reset_n;
    logic start;
    logic [num_kernels-1:0] skip_en;
    logic [addr_width-1:0] start_a [num_kernels];
    logic [addr_width-1:0] end_a [num_kernels];
    logic [num_kernels-1:0] wrap_en;
    logic [count_width-1:0] fifo_cnt [num_kernels];
    logic [data_width-1:0] wr_data [num_kernels];
    logic [num_kernels-1:0] wr_en;
    logic [addr_width-1:0] m_axi_araddr;
    logic m_axi_arvalid;
    logic m_axi_arready = 1'b0;
    logic [data_width-1:0] m_axi_rdata = '0;
    logic m_axi_rlast = 1'b0;
    logic m_axi_rvalid = 1'b0;
    logic m_axi_rready;

    // memory model state
    logic [31:0] lfsr = 32'h6a7b4a6a;
    logic        busy;
    logic [2:0]  beat;
    logic [2:0]  delay;
    logic [31:0] base;
    int          writes [num_kernels];
    int          waited;

    always #4 clk = ~clk;

    kernel_loader kernel_loader_inst (
        .clk(clk), .reset_n(reset_n), .start(start), .skip_en(skip_en),
        .kernel_0_start_addr(start_a[0]), .kernel_0_end_addr(end_a[0]),
        .kernel_0_wrap_en(wrap_en[0]), .kernel_0_fifo_count(fifo_cnt[0]),
        .kernel_0_fifo_wr_data(wr_data[0]), .kernel_0_fifo_wr_en(wr_en[0]),
        .kernel_1_start_addr(start_a[1]), .kernel_1_end_addr(end_a[1]),
        .kernel_1_wrap_en(wrap_en[1]), .kernel_1_fifo_count(fifo_cnt[1]),
        .kernel_1_fifo_wr_data(wr_data[1]), .kernel_1_fifo_wr_en(wr_en[1]),
        .kernel_2_start_addr(start_a[2]), .kernel_2_end_addr(end_a[2]),
        .kernel_2_wrap_en(wrap_en[2]), .kernel_2_fifo_count(fifo_cnt[2]),
        .kernel_2_fifo_wr_data(wr_data[2]), .kernel_2_fifo_wr_en(wr_en[2]),
        .kernel_3_start_addr(start_a[3]), .kernel_3_end_addr(end_a[3]),
        .kernel_3_wrap_en(wrap_en[3]), .kernel_3_fifo_count(fifo_cnt[3]),
        .kernel_3_fifo_wr_data(wr_data[3]), .kernel_3_fifo_wr_en(wr_en[3]),
        .kernel_4_start_addr(start_a[4]), .kernel_4_end_addr(end_a[4]),
        .kernel_4_wrap_en(wrap_en[4]), .kernel_4_fifo_count(fifo_cnt[4]),
        .kernel_4_fifo_wr_data(wr_data[4]), .kernel_4_fifo_wr_en(wr_en[4]),
        .m_axi_araddr(m_axi_araddr), .m_axi_arvalid(m_axi_arvalid),
        .m_axi_arready(m_axi_arready), .m_axi_rdata(m_axi_rdata),
        .m_axi_rlast(m_axi_rlast), .m_axi_rvalid(m_axi_rvalid),
        .m_axi_rready(m_axi_rready)
    );

    // galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ****************************************
    // AXI memory model
    // ****************************************

    always @(posedge clk) begin
        if (!reset_n) begin
            m_axi_arready <= 1'b0;
            m_axi_rvalid  <= 1'b0;
            m_axi_rlast   <= 1'b0;
            m_axi_rdata   <= '0;
            busy          <= 1'b0;
        end else if (!busy) begin
            if (m_axi_arvalid && m_axi_arready) begin
                busy          <= 1'b1;
                base          <= m_axi_araddr;
                beat          <= '0;
                delay         <= 3'(take_bits(3));
                m_axi_arready <= 1'b0;
            end else begin
                m_axi_arready <= 1'(take_bits(1));
            end
        end else if (m_axi_rvalid && m_axi_rready) begin
            if (beat == 3'd7) begin
                busy         <= 1'b0;
                m_axi_rvalid <= 1'b0;
                m_axi_rlast  <= 1'b0;
            end else begin
                beat         <= beat + 1'b1;
                m_axi_rdata  <= {~(base + 8 * (beat + 1)), base + 8 * (beat + 1)};
                m_axi_rlast  <= (beat == 3'd6);
                m_axi_rvalid <= 1'(take_bits(1));
            end
        end else if (!m_axi_rvalid) begin
            if (delay != 0) begin
                delay <= delay - 1'b1;
            end else begin
                m_axi_rdata  <= {~(base + 8 * beat), base + 8 * beat};
                m_axi_rlast  <= (beat == 3'd7);
                m_axi_rvalid <= 1'(take_bits(1));
            end
        end
    end

    always @(posedge clk) begin
        for (int k = 0; k < num_kernels; k++) begin
            if (!reset_n || start) begin
                writes[k] <= 0;
            end else if (wr_en[k]) begin
                writes[k] <= writes[k] + 1;
            end
        end
    end

    // stop at the first failing assertion
    always @(negedge clk) begin
        if (kernel_loader_inst.u_assert.fail_count != 0) begin
            $display("[FAIL] %0t: assertion check failed", $time);
            $display("Test failures found");
            $fatal(1);
        end
    end

    initial begin
        reset_n  <= 1'b0;
        start    <= 1'b0;
        skip_en  <= 5'b00010;
        wrap_en  <= 5'b00100;
        for (int k = 0; k < num_kernels; k++) begin
            start_a[k]  <= 32'h1000 * (k + 1);
            end_a[k]    <= 32'h1000 * (k + 1) + 32'h80;
            fifo_cnt[k] <= 8'd10;
        end
        // kernel 3 almost full, kernel 4 three bursts long
        fifo_cnt[3] <= 8'd210;
        end_a[4]    <= 32'h50c0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        waited = 0;
        while ((writes[0] < 16 || writes[4] < 24) && waited < 20000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 20000) begin
            $display("timeout waiting for kernels 0 and 4 to finish");
            $display("Test failures found");
            $fatal(1);
        end

        // kernel 2 runs on past its second wrap
        // and kernels 0 and 4 come up again after their end address
        waited = 0;
        while (writes[2] < 40 && waited < 20000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 20000) begin
            $display("timeout waiting for kernel 2 to wrap");
            $display("Test failures found");
            $fatal(1);
        end

        @(negedge clk);
        if (kernel_loader_inst.u_assert.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

// File: tb.f
verilog/kernel_loader_pkg.sv
verilog/kernel_channel.sv
verilog/kernel_scheduler.sv
verilog/axi_burst_reader.sv
verilog/kernel_loader.sv
tests/kernel_loader_assertions.sv
tests/kernel_loader_tb.sv
